/* pet_bridge_pkg.sv */
// Shared bridge constants that assume ADDR_WIDTH = 2*DATA_WIDTH+1 and a power-of-two DATA_WIDTH
`default_nettype none

package pet_bridge_pkg;

    // Bus and SPI byte width
    localparam int DATA_WIDTH = 8;

    // Bus address width, 128 KiB of byte-wide space
    localparam int ADDR_WIDTH = 17;

    // SPI bit counter width
    localparam int BIT_CNT_WIDTH = $clog2(DATA_WIDTH);     // Wraps once per byte

    // Command byte layout
    // Bit 7 picks the direction and bit 6 picks set or increment
    localparam int CMD_WE_BIT       = 7;                    // 1 = write, a data byte follows
    localparam int CMD_SET_ADDR_BIT = 6;                    // 1 = two address bytes follow
    localparam int CMD_A16_BIT      = 0;                    // Address bit 16 on set-address

    // Order of bytes after the command byte
    // data (writes only), then address high, then address low (set-address only)

    // RAM target timing
    localparam int RAM_WAIT_STATES = 2;                     // Clocks from cycle start to ack
    localparam int WAIT_CNT_WIDTH  = $clog2(RAM_WAIT_STATES + 1);  // Holds 0..RAM_WAIT_STATES

    // Wait states must stay at 1 or more
    // A value of 0 would need a combinational ack, which the RAM does not provide

endpackage

`default_nettype wire

/* bus_if.sv */
// Byte-wide memory bus with one cycle in flight, the target acks each cycle exactly once
`default_nettype none
`timescale 1ns/100ps

interface bus_if;
    import pet_bridge_pkg::*;

    // Master side
    logic [ADDR_WIDTH-1:0] addr;    // Held stable while cycle is high
    logic [DATA_WIDTH-1:0] wdata;   // Byte to write
    logic                  we;      // 1 = write, 0 = read
    logic                  cycle;   // Requests a bus cycle, dropped the clock after ack

    // Target side
    logic [DATA_WIDTH-1:0] rdata;   // Valid with ack, echoes wdata on a write
    logic                  ack;     // One-clock pulse that ends the cycle

    modport master (
        output addr,
        output wdata,
        output we,
        output cycle,
        input  rdata,
        input  ack
    );

    modport target (
        input  addr,
        input  wdata,
        input  we,
        input  cycle,
        output rdata,
        output ack
    );
endinterface

`default_nettype wire

/* spi_target.sv */
// SPI mode 0 target, MSB first; spi_cs_n_i must go high once before the first transfer
`default_nettype none
`timescale 1ns/100ps

module spi_target (
    input  wire logic                                spi_cs_n_i,  // Chip select, high clears
    input  wire logic                                spi_sck_i,   // Serial clock from the MCU
    input  wire logic                                spi_sd_i,    // SDI, sampled on rising SCK
    output logic                                     spi_sd_o,    // SDO, shifted on falling SCK
    input  wire logic [pet_bridge_pkg::DATA_WIDTH-1:0] tx_data_i, // Byte to send, held per byte
    output logic      [pet_bridge_pkg::DATA_WIDTH-1:0] rx_data_o, // Received byte
    output logic                                     byte_done_o  // High at the last bit's edge
);
    import pet_bridge_pkg::*;

    logic [BIT_CNT_WIDTH-1:0] bit_cnt;      // Bits taken in the current byte
    logic [DATA_WIDTH-2:0]    rx_shift;     // First seven bits of the byte
    logic [DATA_WIDTH-1:0]    tx_shift;     // Bits still to go out, MSB on top
    logic                     tx_active;    // Set once the first bit of a byte is out

    // Bit counter on rising SCK
    always_ff @(posedge spi_sck_i or posedge spi_cs_n_i) begin
        if (spi_cs_n_i) begin
            bit_cnt <= '0;                  // Deselect restarts at the first bit
        end else begin
            bit_cnt <= bit_cnt + 1'b1;      // Rolls over to 0 after the last bit
        end
    end

    // Receive side
    always_ff @(posedge spi_sck_i) begin
        rx_shift <= {rx_shift[DATA_WIDTH-3:0], spi_sd_i};
    end

    // The last bit comes straight from SDI
    // so the whole byte is there at the edge that completes it
    assign rx_data_o   = {rx_shift, spi_sd_i};
    assign byte_done_o = &bit_cnt;          // Counter at DATA_WIDTH-1

    // Transmit side
    always_ff @(negedge spi_sck_i or posedge spi_cs_n_i) begin
        if (spi_cs_n_i) begin
            tx_active <= 1'b0;
        end else begin
            tx_active <= |bit_cnt;          // Low again after the last bit of a byte
        end
    end

    always_ff @(negedge spi_sck_i) begin
        if (!tx_active) begin
            // First falling edge of a byte, MSB is already on SDO
            tx_shift <= {tx_data_i[DATA_WIDTH-2:0], 1'b0};
        end else begin
            tx_shift <= {tx_shift[DATA_WIDTH-2:0], 1'b0};
        end
    end

    // MSB of the new byte shows as soon as a byte starts
    assign spi_sd_o = tx_active ? tx_shift[DATA_WIDTH-1] : tx_data_i[DATA_WIDTH-1];

endmodule

`default_nettype wire

/* sync2_edge_detect.sv */
// Two-flop synchronizer with edge pulses; data_i must hold each level for more than 2 clocks
`default_nettype none
`timescale 1ns/100ps

module sync2_edge_detect (
    input  wire logic clock_i,      // Destination clock
    input  wire logic arst_n_i,     // Async reset, active low
    input  wire logic data_i,       // Level from another clock domain
    output logic      rise_o,       // One-clock pulse on a rising edge
    output logic      fall_o        // One-clock pulse on a falling edge
);
    // [0] and [1] form the synchronizer
    // [2] keeps the previous synchronized value
    logic [2:0] sync_q;

    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync_q <= '1;           // Starts high like a deselected chip select
        end else begin
            sync_q <= {sync_q[1:0], data_i};
        end
    end

    // Edges of the synchronized level
    assign rise_o = sync_q[1] & ~sync_q[2];
    assign fall_o = ~sync_q[1] & sync_q[2];

endmodule

`default_nettype wire

/* spi_bus_master.sv */
// SPI command to bus cycle bridge; the MCU must see spi_stall_o low before each chip select change
`default_nettype none
`timescale 1ns/100ps

module spi_bus_master (
    input  wire logic clock_i,      // Bus clock
    input  wire logic arst_n_i,     // Async reset, active low
    input  wire logic spi_cs_n_i,   // Chip select, active low
    input  wire logic spi_sck_i,    // Serial clock
    input  wire logic spi_sd_i,     // MCU to bridge
    output logic      spi_sd_o,     // Bridge to MCU
    output logic      spi_stall_o,  // Command being received or carried out
    bus_if.master     bus           // Memory bus
);
    import pet_bridge_pkg::*;

    // SCK domain
    logic [DATA_WIDTH-1:0] rx_data;     // Byte from the MCU
    logic                  byte_done;   // rx_data complete at this rising SCK edge
    logic [DATA_WIDTH-1:0] tx_data;     // rdata of the last cycle, sent on the next transaction

    spi_target i_spi_target (
        .spi_cs_n_i (spi_cs_n_i),
        .spi_sck_i  (spi_sck_i),
        .spi_sd_i   (spi_sd_i),
        .spi_sd_o   (spi_sd_o),
        .tx_data_i  (tx_data),
        .rx_data_o  (rx_data),
        .byte_done_o(byte_done)
    );

    // Command decoder states
    typedef enum logic [2:0] {
        DEC_CMD      = 3'b000,
        DEC_DATA     = 3'b001,
        DEC_ADDR_HI  = 3'b010,
        DEC_ADDR_LO  = 3'b011,
        DEC_COMPLETE = 3'b100          // Only state with bit 2 set
    } dec_state_t;

    dec_state_t dec_state;
    logic       set_addr;               // Current command carries address bytes
    logic       cmd_byte;               // Strobes, one per byte position
    logic       data_byte;
    logic       addr_hi_byte;
    logic       addr_lo_byte;
    logic       cmd_done;               // Flop output, safe to cross domains

    assign cmd_byte     = byte_done && (dec_state == DEC_CMD);
    assign data_byte    = byte_done && (dec_state == DEC_DATA);
    assign addr_hi_byte = byte_done && (dec_state == DEC_ADDR_HI);
    assign addr_lo_byte = byte_done && (dec_state == DEC_ADDR_LO);
    assign cmd_done     = dec_state[2];

    always_ff @(posedge spi_sck_i or posedge spi_cs_n_i) begin
        if (spi_cs_n_i) begin
            dec_state <= DEC_CMD;       // Each transaction starts with a command byte
        end else if (byte_done) begin
            case (dec_state)
                DEC_CMD: begin
                    if (rx_data[CMD_WE_BIT]) begin
                        dec_state <= DEC_DATA;
                    end else if (rx_data[CMD_SET_ADDR_BIT]) begin
                        dec_state <= DEC_ADDR_HI;
                    end else begin
                        dec_state <= DEC_COMPLETE;  // Read at the next address
                    end
                end
                DEC_DATA:    dec_state <= set_addr ? DEC_ADDR_HI : DEC_COMPLETE;
                DEC_ADDR_HI: dec_state <= DEC_ADDR_LO;
                DEC_ADDR_LO: dec_state <= DEC_COMPLETE;
                default:     dec_state <= DEC_COMPLETE;  // Extra bytes are ignored
            endcase
        end
    end

    // Direction, flags and write data
    always_ff @(posedge spi_sck_i) begin
        if (cmd_byte) begin
            bus.we   <= rx_data[CMD_WE_BIT];
            set_addr <= rx_data[CMD_SET_ADDR_BIT];
        end
        if (data_byte) begin
            bus.wdata <= rx_data;
        end
    end

    // Address register, kept across transactions
    always_ff @(posedge spi_sck_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bus.addr <= '0;
        end else if (cmd_byte) begin
            if (rx_data[CMD_SET_ADDR_BIT]) begin
                bus.addr[ADDR_WIDTH-1] <= rx_data[CMD_A16_BIT];  // Low bits follow
            end else begin
                bus.addr <= bus.addr + 1'b1;                   // Carries into bit 16
            end
        end else if (addr_hi_byte) begin
            bus.addr[2*DATA_WIDTH-1:DATA_WIDTH] <= rx_data;
        end else if (addr_lo_byte) begin
            bus.addr[DATA_WIDTH-1:0] <= rx_data;
        end
    end

    // Crossing into clock_i
    logic cs_fall;                      // Transaction started
    logic cs_rise;                      // Transaction ended
    logic cmd_rise;                     // Command complete

    sync2_edge_detect i_sync_cs (
        .clock_i (clock_i),
        .arst_n_i(arst_n_i),
        .data_i  (spi_cs_n_i),
        .rise_o  (cs_rise),
        .fall_o  (cs_fall)
    );

    sync2_edge_detect i_sync_cmd (
        .clock_i (clock_i),
        .arst_n_i(arst_n_i),
        .data_i  (cmd_done),
        .rise_o  (cmd_rise),
        .fall_o  ()                     // Decoder clears with chip select
    );

    // Bus FSM, bit 0 is stall and bit 1 is cycle
    typedef enum logic [1:0] {
        ST_IDLE    = 2'b00,
        ST_RECEIVE = 2'b01,
        ST_BUS     = 2'b11
    } bus_state_t;

    bus_state_t bus_state;

    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bus_state <= ST_IDLE;
            tx_data   <= '0;            // First transaction returns 0
        end else if (cs_rise) begin
            bus_state <= ST_IDLE;
        end else begin
            case (bus_state)
                ST_IDLE:    if (cs_fall)  bus_state <= ST_RECEIVE;
                ST_RECEIVE: if (cmd_rise) bus_state <= ST_BUS;
                ST_BUS: begin
                    if (bus.ack) begin
                        tx_data   <= bus.rdata;  // Goes out on the next first byte
                        bus_state <= ST_IDLE;
                    end
                end
                default:    bus_state <= ST_IDLE;
            endcase
        end
    end

    assign spi_stall_o = bus_state[0];
    assign bus.cycle   = bus_state[1];   // Held until ack

endmodule

`default_nettype wire

/* bus_ram.sv */
// Byte-wide RAM bus target with fixed wait states and no reset of its contents
`default_nettype none
`timescale 1ns/100ps

module bus_ram (
    input  wire logic clock_i,      // Bus clock
    input  wire logic arst_n_i,     // Async reset, active low
    bus_if.target     bus           // Memory bus
);
    import pet_bridge_pkg::*;

    logic [DATA_WIDTH-1:0]     mem [2**ADDR_WIDTH];  // 128 KiB storage
    logic [WAIT_CNT_WIDTH-1:0] wait_cnt;             // Clocks since cycle rose, saturates
    logic                      fire;                 // Last wait state of the cycle

    // Fires once per cycle, since the counter stops at RAM_WAIT_STATES
    assign fire = bus.cycle && (wait_cnt == WAIT_CNT_WIDTH'(RAM_WAIT_STATES - 1));

    // Wait counter and ack
    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wait_cnt <= '0;
            bus.ack  <= 1'b0;
        end else begin
            bus.ack <= fire;                        // One-clock pulse
            if (!bus.cycle) begin
                wait_cnt <= '0;                     // Ready for the next rising cycle
            end else if (wait_cnt != WAIT_CNT_WIDTH'(RAM_WAIT_STATES)) begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end
    end

    // Storage access on the same edge as ack
    always_ff @(posedge clock_i) begin
        if (fire) begin
            if (bus.we) begin
                mem[bus.addr] <= bus.wdata;
                bus.rdata     <= bus.wdata;         // Write echoes its byte
            end else begin
                bus.rdata <= mem[bus.addr];
            end
        end
    end

endmodule

`default_nettype wire

/* pet_bridge_top.sv */
// SPI bridge with its RAM target; RAM contents are undefined until written
`default_nettype none
`timescale 1ns/100ps

module pet_bridge_top (
    input  wire logic clock_i,      // Bus clock
    input  wire logic arst_n_i,     // Async reset, active low
    input  wire logic spi_cs_n_i,   // SPI chip select, active low
    input  wire logic spi_sck_i,    // SPI clock, mode 0
    input  wire logic spi_sd_i,     // SDI from the MCU
    output logic      spi_sd_o,     // SDO to the MCU
    output logic      spi_stall_o   // Flow control to the MCU
);
    // Memory bus between bridge and RAM
    bus_if bus ();

    // SPI side, bus master
    spi_bus_master i_spi_bus_master (
        .clock_i    (clock_i),
        .arst_n_i   (arst_n_i),
        .spi_cs_n_i (spi_cs_n_i),
        .spi_sck_i  (spi_sck_i),
        .spi_sd_i   (spi_sd_i),
        .spi_sd_o   (spi_sd_o),
        .spi_stall_o(spi_stall_o),
        .bus        (bus.master)
    );

    // On-chip RAM, bus target
    bus_ram i_bus_ram (
        .clock_i (clock_i),
        .arst_n_i(arst_n_i),
        .bus     (bus.target)
    );

endmodule

`default_nettype wire

/* pet_bridge_tb.sv */
// Self-checking testbench that needs simulator timing support and leaves reads of never-written bytes unchecked
`default_nettype none
`timescale 1ns/100ps

module pet_bridge_tb;
    import pet_bridge_pkg::*;

    localparam int FILL_LEN    = 32;                        // Bytes in the fill window
    localparam int WIN_BASE    = 'h0_fff0;                  // Window straddles the bit 16 carry
    localparam int N_DIRECTED  = 4 + 2 * FILL_LEN;          // Set-address pairs, fill, read-back
    localparam int N_RANDOM    = 200;
    localparam int N_TRANS     = N_DIRECTED + N_RANDOM + 1; // Last one flushes the final result
    localparam int TIMEOUT_NS  = N_TRANS * 4000;            // 4 us per transaction
    localparam int STALL_LIMIT = 64;                        // Clocks allowed for one bus command

    logic clock_i;
    logic arst_n_i;
    logic spi_cs_n_i;
    logic spi_sck_i;
    logic spi_sd_i;
    logic spi_sd_o;
    logic spi_stall_o;

    // Reference model state
    logic [7:0]            shadow [int];    // Bytes written so far
    logic [ADDR_WIDTH-1:0] ref_addr;        // Address used by the last command

    // Expected bytes in transaction order and bytes seen on SDO
    logic [7:0] exp_val_q [$];
    logic       exp_known_q [$];
    string      exp_name_q [$];
    logic [7:0] got_q [$];

    int n_errors;
    int n_checks;
    int n_skipped;

    pet_bridge_top i_pet_bridge_top (
        .clock_i    (clock_i),
        .arst_n_i   (arst_n_i),
        .spi_cs_n_i (spi_cs_n_i),
        .spi_sck_i  (spi_sck_i),
        .spi_sd_i   (spi_sd_i),
        .spi_sd_o   (spi_sd_o),
        .spi_stall_o(spi_stall_o)
    );

    initial begin
        clock_i = 1'b0;
        forever #5 clock_i = ~clock_i;      // 100 MHz
    end

    // Bus result of one command by the command byte rules
    function automatic logic [7:0] ref_result(input logic [7:0] cmd, input logic [7:0] data,
                                              input logic [7:0] addr_hi,
                                              input logic [7:0] addr_lo, output logic known);
        logic [7:0] result;
        if (cmd[CMD_SET_ADDR_BIT]) begin
            ref_addr = {cmd[CMD_A16_BIT], addr_hi, addr_lo};
        end else begin
            ref_addr = ref_addr + 1'b1;                 // Previous address plus one
        end
        known  = 1'b1;
        result = 8'h00;
        if (cmd[CMD_WE_BIT]) begin
            shadow[int'(ref_addr)] = data;
            result = data;                              // Write echoes its byte
        end else if (shadow.exists(int'(ref_addr))) begin
            result = shadow[int'(ref_addr)];
        end else begin
            known = 1'b0;                               // RAM content undefined
        end
        return result;
    endfunction

    // Bounded wait for the bridge to drop stall
    task automatic wait_stall_low(input string name, input string where);
        int n;
        n = 0;
        while (spi_stall_o && n < STALL_LIMIT) begin
            @(posedge clock_i);
            n++;
        end
        if (spi_stall_o) begin
            $display("%s: spi_stall_o still high %s after %0d clocks", name, where, STALL_LIMIT);
            n_errors++;
        end
    endtask

    // One SPI transaction with SCK at 4 clocks per bit
    task automatic spi_transfer(input logic [7:0] tx_bytes [4], input int n_bytes,
                                input string name);
        logic [7:0] rx_byte;
        rx_byte = 8'h00;
        wait_stall_low(name, "before chip select falls");
        @(posedge clock_i);
        spi_cs_n_i <= 1'b0;
        repeat (5) @(posedge clock_i);
        if (!spi_stall_o) begin
            $display("%s: spi_stall_o did not rise after chip select fell", name);
            n_errors++;
        end
        for (int b = 0; b < n_bytes; b++) begin
            for (int k = DATA_WIDTH - 1; k >= 0; k--) begin
                @(posedge clock_i);
                spi_sck_i <= 1'b0;                      // SCK falls and SDI changes
                spi_sd_i  <= tx_bytes[b][k];            // MSB first
                @(posedge clock_i);
                @(posedge clock_i);
                if (b == 0) begin
                    rx_byte[k] = spi_sd_o;              // Sampled just before rising SCK
                end
                spi_sck_i <= 1'b1;
                @(posedge clock_i);
            end
        end
        @(posedge clock_i);
        spi_sck_i <= 1'b0;                              // Mode 0 idles low
        got_q.push_back(rx_byte);                       // Result of the previous command
        wait_stall_low(name, "before chip select rises");
        @(posedge clock_i);
        spi_cs_n_i <= 1'b1;
        repeat (4) @(posedge clock_i);                  // Deselect long enough to sync
    endtask

    // Build the bytes of a command and queue its expected result
    task automatic run_command(input logic [7:0] cmd, input logic [7:0] data,
                               input logic [ADDR_WIDTH-1:0] addr, input string name);
        logic [7:0] tx_bytes [4];
        logic [7:0] cmd_byte;
        logic [7:0] expected;
        logic       known;
        int         n_bytes;
        cmd_byte = cmd;
        if (cmd[CMD_SET_ADDR_BIT]) begin
            cmd_byte[CMD_A16_BIT] = addr[ADDR_WIDTH-1];
        end
        tx_bytes[0] = cmd_byte;
        tx_bytes[1] = 8'h00;
        tx_bytes[2] = 8'h00;
        tx_bytes[3] = 8'h00;
        n_bytes = 1;
        if (cmd_byte[CMD_WE_BIT]) begin
            tx_bytes[n_bytes] = data;
            n_bytes++;
        end
        if (cmd_byte[CMD_SET_ADDR_BIT]) begin
            tx_bytes[n_bytes] = addr[2*DATA_WIDTH-1:DATA_WIDTH];   // High byte first
            n_bytes++;
            tx_bytes[n_bytes] = addr[DATA_WIDTH-1:0];
            n_bytes++;
        end
        expected = ref_result(cmd_byte, data, addr[2*DATA_WIDTH-1:DATA_WIDTH],
                              addr[DATA_WIDTH-1:0], known);
        exp_val_q.push_back(expected);
        exp_known_q.push_back(known);
        exp_name_q.push_back(name);
        spi_transfer(tx_bytes, n_bytes, name);
    endtask

    // Compare each returned byte with the model
    always @(posedge clock_i) begin : compare_returned
        logic [7:0] got;
        logic [7:0] expected;
        logic       known;
        string      name;
        if (got_q.size() > 0) begin
            got      = got_q.pop_front();
            expected = exp_val_q.pop_front();
            known    = exp_known_q.pop_front();
            name     = exp_name_q.pop_front();
            if (!known) begin
                n_skipped++;                            // Read of a byte never written
            end else begin
                n_checks++;
                if (got !== expected) begin
                    $display("FAIL %s: expected 8'h%02h, actual 8'h%02h",
                             name, expected, got);
                    n_errors++;
                end
            end
        end
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Errors found");
        $finish;
    end

    initial begin
        logic [7:0]            cmd;
        logic [ADDR_WIDTH-1:0] addr;
        void'($urandom(32'h9ac5_86af));
        arst_n_i   <= 1'b0;
        spi_cs_n_i <= 1'b1;
        spi_sck_i  <= 1'b0;
        spi_sd_i   <= 1'b0;
        ref_addr   = '0;                                // Address register resets to 0
        n_errors   = 0;
        n_checks   = 0;
        n_skipped  = 0;
        exp_val_q.push_back(8'h00);                     // First transaction returns 0
        exp_known_q.push_back(1'b1);
        exp_name_q.push_back("reset_value");
        @(posedge clock_i);
        spi_cs_n_i <= 1'b0;
        @(posedge clock_i);
        spi_cs_n_i <= 1'b1;                             // Deselect edge clears the SCK side
        @(posedge clock_i);
        arst_n_i <= 1'b1;
        repeat (2) @(posedge clock_i);
        if (spi_stall_o !== 1'b0) begin
            $display("spi_stall_o is not low after reset");
            n_errors++;
        end

        // Set-address write and read-back of the same byte
        run_command(8'hc0, 8'ha5, 17'h0_1234, "set_write");
        run_command(8'h40, 8'h00, 17'h0_1234, "set_read");
        run_command(8'hc0, 8'h3c, 17'h1_5a5a, "set_write_a16");
        run_command(8'h40, 8'h00, 17'h1_5a5a, "set_read_a16");

        // Incrementing fill and read-back across the carry into bit 16
        run_command(8'hc0, 8'($urandom), ADDR_WIDTH'(WIN_BASE), "inc_write");
        for (int i = 1; i < FILL_LEN; i++) begin
            run_command(8'h80, 8'($urandom), '0, "inc_write");
        end
        run_command(8'h40, 8'h00, ADDR_WIDTH'(WIN_BASE), "inc_read");
        for (int i = 1; i < FILL_LEN; i++) begin
            run_command(8'h00, 8'h00, '0, "inc_read");
        end

        // Random mix inside the filled window
        for (int i = 0; i < N_RANDOM; i++) begin
            cmd  = 8'($urandom);
            addr = ADDR_WIDTH'(WIN_BASE + ($urandom % FILL_LEN));
            run_command(cmd, 8'($urandom), addr, $sformatf("random_%0d", i));
        end

        run_command(8'h00, 8'h00, '0, "flush");         // Brings back the last result
        repeat (4) @(posedge clock_i);                  // Last returned byte gets compared
        $display("Checks: %0d, unchecked: %0d, errors: %0d", n_checks, n_skipped, n_errors);
        if (n_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* pet_bridge_top.f */
pet_bridge_pkg.sv
bus_if.sv
spi_target.sv
sync2_edge_detect.sv
spi_bus_master.sv
bus_ram.sv
pet_bridge_top.sv
pet_bridge_tb.sv

/* Makefile */
# Verilator build and run of the SPI bridge testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench, fails unless the log holds the pass line"
	@echo "make clean  remove the build folder and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --top-module pet_bridge_tb -f pet_bridge_top.f \
		--Mdir obj_dir -o pet_bridge_tb
	./obj_dir/pet_bridge_tb > $(LOG) 2>&1; cat $(LOG)
	grep -qx "No errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
